// File: rtl/btc_pkg.sv
package btc_pkg;

  // ----------------------------------------------------------
  // block geometry
  // ----------------------------------------------------------
  localparam int BLK_ROWS = 8;  // rows per block, last one is the parity row
  localparam int ROW_W    = 8;  // 7 data bits + 1 even parity bit
  localparam int ROW_AW   = 3;  // row address into the block ram

  // ----------------------------------------------------------
  // wishbone register map
  // ----------------------------------------------------------
  localparam int WB_AW = 4;  // 0..7 rows, 8.. registers

  // write starts a decode
  // read gives busy in [7], outcome in [1:0]
  localparam logic [WB_AW-1:0] ADR_CTRL = 4'd8;
  // read gives error row in [5:3], error column in [2:0]
  localparam logic [WB_AW-1:0] ADR_LOC  = 4'd9;

  // decode outcome
  typedef enum logic [1:0] {
    RES_CLEAN = 2'd0,  // no parity fails
    RES_FIXED = 2'd1,  // one row, one column, bit flipped
    RES_FAIL  = 2'd2   // anything else, block untouched
  } dec_res_t;

endpackage

// File: rtl/btc_dec_mem.sv
`timescale 1ns/100ps

module btc_dec_mem #(
  parameter int addr_w = 3,
  parameter int dat_w  = 8
) (
  input  logic              iclk,
  // write side
  input  logic              write,
  input  logic [addr_w-1:0] waddr,
  input  logic [dat_w-1:0]  wdat,
  // read side, one tick latency
  input  logic [addr_w-1:0] raddr,
  output logic [dat_w-1:0]  rdat
);

  logic [dat_w-1:0] mem [2**addr_w];  // storage array

  // ----------------------------------------------------------
  // write port
  // ----------------------------------------------------------
  always_ff @(posedge iclk) begin
    if (write) begin
      mem[waddr] <= wdat;
    end
  end

  // ----------------------------------------------------------
  // registered read port
  // ----------------------------------------------------------
  always_ff @(posedge iclk) begin
    rdat <= mem[raddr];  // old data on a same-address write
  end

endmodule

// File: rtl/btc_row_check.sv
`timescale 1ns/100ps

module btc_row_check
  import btc_pkg::*;
(
  input  logic              iclk,
  input  logic              rst_n,
  input  logic              sweep_first,   // first row of a sweep
  input  logic              row_vld,       // mem_rdat holds a row
  input  logic [ROW_AW-1:0] sweep_idx,     // row number of mem_rdat
  input  logic [ROW_W-1:0]  mem_rdat,
  output logic [1:0]        row_fail_cnt,  // saturates at 2
  output logic [ROW_AW-1:0] row_fail_idx   // last failing row
);

  logic fail;  // row parity fail

  assign fail = ^mem_rdat;  // even parity, any odd weight is a fail

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      row_fail_cnt <= '0;
      row_fail_idx <= '0;
    end else if (row_vld) begin
      if (sweep_first) begin
        // restart the count with this row
        row_fail_cnt <= {1'b0, fail};
        row_fail_idx <= fail ? sweep_idx : '0;
      end else if (fail) begin
        if (row_fail_cnt != 2'd2) begin
          row_fail_cnt <= row_fail_cnt + 2'd1;  // 2 means two or more
        end
        row_fail_idx <= sweep_idx;  // only meaningful when count is 1
      end
    end
  end

endmodule

// File: rtl/btc_col_check.sv
`timescale 1ns/100ps

module btc_col_check
  import btc_pkg::*;
(
  input  logic             iclk,
  input  logic             rst_n,
  input  logic             sweep_first,  // load instead of accumulate
  input  logic             row_vld,
  input  logic [ROW_W-1:0] mem_rdat,
  output logic [ROW_W-1:0] col_syn       // one bit per failing column
);

  // ----------------------------------------------------------
  // column syndrome accumulator
  // ----------------------------------------------------------
  // xor of all rows, parity row included, is zero for a codeword.
  // every set bit marks a column with odd weight

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      col_syn <= '0;
    end else if (row_vld) begin
      if (sweep_first) begin
        col_syn <= mem_rdat;  // drop the previous block
      end else begin
        col_syn <= col_syn ^ mem_rdat;
      end
    end
  end

endmodule

// File: rtl/btc_err_locate.sv
`timescale 1ns/100ps

module btc_err_locate
  import btc_pkg::*;
(
  input  logic              iclk,
  input  logic              rst_n,
  input  logic              sweep_done,    // checker results are final
  input  logic [1:0]        row_fail_cnt,
  input  logic [ROW_AW-1:0] row_fail_idx,
  input  logic [ROW_W-1:0]  col_syn,
  output logic              loc_vld,       // one tick after sweep_done
  output dec_res_t          res,
  output logic [ROW_AW-1:0] err_row,
  output logic [ROW_AW-1:0] err_col,
  output logic [ROW_W-1:0]  flip_mask      // one-hot in err_col
);

  logic [3:0]        col_cnt;  // ones in col_syn, up to 8
  logic [ROW_AW-1:0] col_pos;  // position of the highest one
  dec_res_t          res_nxt;

  // ----------------------------------------------------------
  // syndrome weight and position
  // ----------------------------------------------------------
  always_comb begin
    col_cnt = '0;
    col_pos = '0;
    for (int i = 0; i < ROW_W; i++) begin
      if (col_syn[i]) begin
        col_cnt = col_cnt + 4'd1;
        col_pos = ROW_AW'(i);  // exact when weight is 1
      end
    end
  end

  // outcome decision
  always_comb begin
    if (row_fail_cnt == 2'd0 && col_cnt == 4'd0) begin
      res_nxt = RES_CLEAN;
    end else if (row_fail_cnt == 2'd1 && col_cnt == 4'd1) begin
      res_nxt = RES_FIXED;  // single bit at the crossing
    end else begin
      res_nxt = RES_FAIL;
    end
  end

  // ----------------------------------------------------------
  // result registers, held until the next sweep
  // ----------------------------------------------------------
  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      loc_vld   <= 1'b0;
      res       <= RES_CLEAN;
      err_row   <= '0;
      err_col   <= '0;
      flip_mask <= '0;
    end else begin
      loc_vld <= sweep_done;
      if (sweep_done) begin
        res <= res_nxt;
        if (res_nxt == RES_FIXED) begin
          err_row   <= row_fail_idx;
          err_col   <= col_pos;
          flip_mask <= ROW_W'(1) << col_pos;
        end else begin
          err_row   <= '0;  // no location for clean or fail
          err_col   <= '0;
          flip_mask <= '0;
        end
      end
    end
  end

endmodule

// File: rtl/btc_dec_ctrl.sv
`timescale 1ns/100ps

module btc_dec_ctrl
  import btc_pkg::*;
(
  input  logic              iclk,
  input  logic              rst_n,
  // wishbone classic slave
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [WB_AW-1:0]  wb_adr,
  input  logic [ROW_W-1:0]  wb_dat_w,
  output logic [ROW_W-1:0]  wb_dat_r,
  output logic              wb_ack,
  // block memory
  output logic              mem_write,
  output logic [ROW_AW-1:0] mem_waddr,
  output logic [ROW_W-1:0]  mem_wdat,
  output logic [ROW_AW-1:0] mem_raddr,
  input  logic [ROW_W-1:0]  mem_rdat,
  // checkers
  output logic              sweep_first,
  output logic              row_vld,
  output logic [ROW_AW-1:0] sweep_idx,
  output logic              sweep_done,
  // locator
  input  logic              loc_vld,
  input  dec_res_t          res,
  input  logic [ROW_AW-1:0] err_row,
  input  logic [ROW_AW-1:0] err_col,
  input  logic [ROW_W-1:0]  flip_mask
);

  typedef enum logic [2:0] {ST_IDLE, ST_SWEEP, ST_LOC, ST_FIX, ST_DONE} state_t;

  state_t            state;
  logic              busy;
  logic [ROW_AW-1:0] cnt;       // sweep read address
  dec_res_t          res_q;     // outcome register
  logic [ROW_AW-1:0] row_q;     // location register
  logic [ROW_AW-1:0] col_q;
  logic              rd_stage;  // row read waiting on the ram
  logic              rd_zero;   // row read taken while busy
  logic              acc;
  logic              is_row;
  logic              host_wr;
  logic              start;
  logic [ROW_W-1:0]  reg_rdat;

  // ----------------------------------------------------------
  // bus decode
  // ----------------------------------------------------------
  assign acc     = wb_cyc & wb_stb & ~wb_ack & ~rd_stage;  // new access
  assign is_row  = (wb_adr < WB_AW'(BLK_ROWS));
  assign host_wr = acc & wb_we & is_row & ~busy;  // dropped while busy
  assign start   = acc & wb_we & (wb_adr == ADR_CTRL) & ~busy;

  always_comb begin
    case (wb_adr)
      ADR_CTRL: reg_rdat = {busy, 5'b0, res_q};
      ADR_LOC:  reg_rdat = {2'b0, row_q, col_q};
      default:  reg_rdat = '0;  // unmapped reads as zero
    endcase
  end

  // ack one tick after stb for registers and writes, two for row reads
  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      wb_ack   <= 1'b0;
      rd_stage <= 1'b0;
    end else begin
      wb_ack   <= rd_stage | (acc & ~(is_row & ~wb_we));
      rd_stage <= acc & is_row & ~wb_we;
    end
  end

  // read data path
  always_ff @(posedge iclk) begin
    if (acc) begin
      rd_zero <= busy;
    end
    if (rd_stage) begin
      wb_dat_r <= rd_zero ? '0 : mem_rdat;  // ram owned by the sweep
    end else if (acc) begin
      wb_dat_r <= wb_we ? '0 : reg_rdat;
    end
  end

  // ----------------------------------------------------------
  // decode sequencer
  // ----------------------------------------------------------
  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      state       <= ST_IDLE;
      busy        <= 1'b0;
      cnt         <= '0;
      res_q       <= RES_CLEAN;
      row_q       <= '0;
      col_q       <= '0;
      row_vld     <= 1'b0;
      sweep_first <= 1'b0;
      sweep_idx   <= '0;
      sweep_done  <= 1'b0;
    end else begin
      // ram data lags the address by one tick
      row_vld     <= (state == ST_SWEEP);
      sweep_first <= (state == ST_SWEEP) && (cnt == '0);
      sweep_idx   <= cnt;
      sweep_done  <= row_vld && (sweep_idx == ROW_AW'(BLK_ROWS-1));
      if (start) begin
        busy <= 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (busy) begin  // tick after the start ack
            state <= ST_SWEEP;
            cnt   <= '0;
          end
        end
        ST_SWEEP: begin
          cnt <= cnt + 1'b1;
          if (cnt == ROW_AW'(BLK_ROWS-1)) begin
            state <= ST_LOC;
          end
        end
        ST_LOC: begin
          if (loc_vld) begin
            state <= (res == RES_FIXED) ? ST_FIX : ST_DONE;
          end
        end
        default: begin  // fix or done, close the decode
          state <= ST_IDLE;
          busy  <= 1'b0;
          res_q <= res;
          row_q <= err_row;
          col_q <= err_col;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // memory port mux
  // ----------------------------------------------------------
  always_comb begin
    if (state == ST_FIX) begin
      mem_write = 1'b1;  // write back the corrected row
      mem_waddr = err_row;
      mem_wdat  = mem_rdat ^ flip_mask;
    end else begin
      mem_write = host_wr;
      mem_waddr = wb_adr[ROW_AW-1:0];
      mem_wdat  = wb_dat_w;
    end
  end

  always_comb begin
    case (state)
      ST_SWEEP:      mem_raddr = cnt;
      ST_LOC,
      ST_FIX:        mem_raddr = err_row;  // fetch row to fix
      default:       mem_raddr = wb_adr[ROW_AW-1:0];
    endcase
  end

endmodule

// File: rtl/btc_spc_dec.sv
`timescale 1ns/100ps

module btc_spc_dec
  import btc_pkg::*;
(
  input  logic             iclk,
  input  logic             rst_n,
  // wishbone classic slave
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [WB_AW-1:0] wb_adr,
  input  logic [ROW_W-1:0] wb_dat_w,
  output logic [ROW_W-1:0] wb_dat_r,
  output logic             wb_ack
);

  // ----------------------------------------------------------
  // internal nets
  // ----------------------------------------------------------
  logic              mem_write;
  logic [ROW_AW-1:0] mem_waddr;
  logic [ROW_W-1:0]  mem_wdat;
  logic [ROW_AW-1:0] mem_raddr;
  logic [ROW_W-1:0]  mem_rdat;
  //
  logic              sweep_first;
  logic              row_vld;
  logic [ROW_AW-1:0] sweep_idx;
  logic              sweep_done;
  //
  logic [1:0]        row_fail_cnt;
  logic [ROW_AW-1:0] row_fail_idx;
  logic [ROW_W-1:0]  col_syn;
  //
  logic              loc_vld;
  dec_res_t          res;
  logic [ROW_AW-1:0] err_row;
  logic [ROW_AW-1:0] err_col;
  logic [ROW_W-1:0]  flip_mask;

  // bus slave and sequencer
  btc_dec_ctrl i_ctrl (
    .iclk         (iclk),
    .rst_n        (rst_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .mem_write    (mem_write),
    .mem_waddr    (mem_waddr),
    .mem_wdat     (mem_wdat),
    .mem_raddr    (mem_raddr),
    .mem_rdat     (mem_rdat),
    .sweep_first  (sweep_first),
    .row_vld      (row_vld),
    .sweep_idx    (sweep_idx),
    .sweep_done   (sweep_done),
    .loc_vld      (loc_vld),
    .res          (res),
    .err_row      (err_row),
    .err_col      (err_col),
    .flip_mask    (flip_mask)
  );

  // block storage, one row per word
  btc_dec_mem #(
    .addr_w (ROW_AW),
    .dat_w  (ROW_W)
  ) i_mem (
    .iclk  (iclk),
    .write (mem_write),
    .waddr (mem_waddr),
    .wdat  (mem_wdat),
    .raddr (mem_raddr),
    .rdat  (mem_rdat)
  );

  btc_row_check i_row_check (
    .iclk         (iclk),
    .rst_n        (rst_n),
    .sweep_first  (sweep_first),
    .row_vld      (row_vld),
    .sweep_idx    (sweep_idx),
    .mem_rdat     (mem_rdat),
    .row_fail_cnt (row_fail_cnt),
    .row_fail_idx (row_fail_idx)
  );

  btc_col_check i_col_check (
    .iclk        (iclk),
    .rst_n       (rst_n),
    .sweep_first (sweep_first),
    .row_vld     (row_vld),
    .mem_rdat    (mem_rdat),
    .col_syn     (col_syn)
  );

  btc_err_locate i_err_locate (
    .iclk         (iclk),
    .rst_n        (rst_n),
    .sweep_done   (sweep_done),
    .row_fail_cnt (row_fail_cnt),
    .row_fail_idx (row_fail_idx),
    .col_syn      (col_syn),
    .loc_vld      (loc_vld),
    .res          (res),
    .err_row      (err_row),
    .err_col      (err_col),
    .flip_mask    (flip_mask)
  );

endmodule

// File: verif/btc_tb_clk.sv
`timescale 1ns/100ps

module btc_tb_clk (
  output logic iclk,
  output logic rst_n
);

  localparam int RST_CYCLES = 8;  // reset length in clocks

  initial begin
    iclk = 1'b0;
    forever #4 iclk = ~iclk;  // 8 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge iclk);
    rst_n <= 1'b1;  // release on a rising edge
  end

endmodule

// File: verif/btc_spc_dec_tb.sv
`timescale 1ns/100ps

module btc_spc_dec_tb
  import btc_pkg::*;
();

  localparam int BLK_W = BLK_ROWS * ROW_W;  // whole block, row r at [8r +: 8]
  localparam int WD_NS = 300 * 400 * 8;     // blocks * cycles per block * period

  logic             iclk;
  logic             rst_n;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [WB_AW-1:0] wb_adr;
  logic [ROW_W-1:0] wb_dat_w;
  logic [ROW_W-1:0] wb_dat_r;
  logic             wb_ack;

  int          err_cnt   = 0;
  int          chk_cnt   = 0;
  int          test_cnt  = 0;
  logic [31:0] lcg_state = 32'd96;  // generator seed

  btc_tb_clk i_clk (
    .iclk  (iclk),
    .rst_n (rst_n)
  );

  btc_spc_dec i_btc_spc_dec (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'(lcg_next() >> 16) % n;  // upper bits, low ones are weak
  endfunction

  // 7x7 random data, parity bit 7 per row, row 7 holds column parity
  function automatic logic [BLK_W-1:0] make_codeword();
    logic [BLK_W-1:0] blk;
    logic [ROW_W-1:0] row;
    logic [ROW_W-1:0] colp;
    blk  = '0;
    colp = '0;
    for (int r = 0; r < BLK_ROWS - 1; r++) begin
      row[6:0]         = 7'(lcg_next() >> 16);
      row[7]           = ^row[6:0];  // even row parity
      blk[ROW_W*r +: ROW_W] = row;
      colp             = colp ^ row;
    end
    blk[ROW_W*(BLK_ROWS-1) +: ROW_W] = colp;
    return blk;
  endfunction

  function automatic logic [BLK_W-1:0] flip_bit(input logic [BLK_W-1:0] blk, input int pos);
    logic [BLK_W-1:0] out;
    out      = blk;
    out[pos] = ~out[pos];
    return out;
  endfunction

  // ----------------------------------------------------------
  // reference decoder
  // ----------------------------------------------------------
  function automatic void ref_decode(input logic [BLK_W-1:0] blk, output logic [1:0] res,
                                     output logic [2:0] row, output logic [2:0] col,
                                     output logic [BLK_W-1:0] fixed);
    int               n_row;
    int               n_col;
    logic [ROW_W-1:0] syn;
    n_row = 0;
    n_col = 0;
    syn   = '0;
    row   = '0;
    col   = '0;
    for (int r = 0; r < BLK_ROWS; r++) begin
      if (^blk[ROW_W*r +: ROW_W]) begin  // odd weight row
        n_row++;
        row = 3'(r);
      end
      syn = syn ^ blk[ROW_W*r +: ROW_W];
    end
    for (int c = 0; c < ROW_W; c++) begin
      if (syn[c]) begin
        n_col++;
        col = 3'(c);
      end
    end
    fixed = blk;
    if (n_row == 0 && n_col == 0) begin
      res = RES_CLEAN;
    end else if (n_row == 1 && n_col == 1) begin
      res   = RES_FIXED;
      fixed = flip_bit(blk, ROW_W * int'(row) + int'(col));  // bit at the crossing
    end else begin
      res = RES_FAIL;  // block left as is, no location
      row = '0;
      col = '0;
    end
  endfunction

  task automatic check_eq(input logic [BLK_W-1:0] got, input logic [BLK_W-1:0] exp,
                          input string what);
    chk_cnt++;
    if (got !== exp) begin
      $display("error at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // ----------------------------------------------------------
  // wishbone bus model
  // ----------------------------------------------------------
  task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [ROW_W-1:0] dat);
    int n;
    @(posedge iclk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    n = 0;
    do begin
      @(posedge iclk);
      n++;
    end while (!wb_ack && n < 16);
    if (!wb_ack) begin
      $display("the DUT never acked a write to address %0d", adr);
      err_cnt++;
    end
    wb_cyc <= 1'b0;  // drop in the cycle after ack
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [ROW_W-1:0] dat);
    int n;
    @(posedge iclk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    n = 0;
    do begin
      @(posedge iclk);
      n++;
    end while (!wb_ack && n < 16);
    if (!wb_ack) begin
      $display("the DUT never acked a read from address %0d", adr);
      err_cnt++;
    end
    dat    = wb_dat_r;  // pre-edge value, data is stable with ack
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic write_block(input logic [BLK_W-1:0] blk);
    for (int r = 0; r < BLK_ROWS; r++) begin
      wb_write(WB_AW'(r), blk[ROW_W*r +: ROW_W]);
    end
  endtask

  task automatic read_block(output logic [BLK_W-1:0] blk);
    logic [ROW_W-1:0] d;
    for (int r = 0; r < BLK_ROWS; r++) begin
      wb_read(WB_AW'(r), d);
      blk[ROW_W*r +: ROW_W] = d;
    end
  endtask

  // poll the control register until busy drops
  task automatic wait_idle(output logic [ROW_W-1:0] ctrl);
    int n;
    n = 0;
    do begin
      wb_read(ADR_CTRL, ctrl);
      n++;
    end while (ctrl[7] && n < 64);
    if (ctrl[7]) begin
      $display("the decode never finished, busy still set after 64 polls");
      err_cnt++;
    end
  endtask

  // load, decode, read back and compare with the reference
  task automatic run_block(input logic [BLK_W-1:0] blk, output logic [1:0] res_got,
                           output logic [BLK_W-1:0] rb);
    logic [1:0]       e_res;
    logic [2:0]       e_row;
    logic [2:0]       e_col;
    logic [BLK_W-1:0] e_blk;
    logic [ROW_W-1:0] d;
    ref_decode(blk, e_res, e_row, e_col, e_blk);
    write_block(blk);
    wb_write(ADR_CTRL, 8'h01);  // start
    wait_idle(d);
    res_got = d[1:0];
    check_eq(d[1:0], e_res, "outcome");
    wb_read(ADR_LOC, d);
    check_eq(d, {2'b00, e_row, e_col}, "error location");
    read_block(rb);
    check_eq(rb, e_blk, "block after decode");
  endtask

  task automatic report_test(input string name, input int err0);
    test_cnt++;
    $display("test %0d %s finished with %0d errors", test_cnt, name, err_cnt - err0);
  endtask

  // ----------------------------------------------------------
  // test flow
  // ----------------------------------------------------------
  initial begin
    logic [BLK_W-1:0] cw;
    logic [BLK_W-1:0] blk;
    logic [BLK_W-1:0] rb;
    logic [ROW_W-1:0] d;
    logic [1:0]       res;
    int               pos;
    int               r1;
    int               r2;
    int               c1;
    int               c2;
    int               idx;
    int               err0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_w <= '0;
    wait (rst_n === 1'b1);

    // 1: loopback and reset values
    err0 = err_cnt;
    wb_read(ADR_CTRL, d);
    check_eq(d, 8'h00, "control after reset");  // idle, clean
    wb_read(ADR_LOC, d);
    check_eq(d, 8'h00, "location after reset");
    blk = {lcg_next(), lcg_next()};
    write_block(blk);
    read_block(rb);
    check_eq(rb, blk, "loopback rows");
    report_test("loopback", err0);

    // 2: clean codeword
    err0 = err_cnt;
    cw   = make_codeword();
    run_block(cw, res, rb);
    check_eq(res, RES_CLEAN, "clean outcome");
    check_eq(rb, cw, "clean block unchanged");
    report_test("clean codeword", err0);

    // 3: one flipped bit
    err0 = err_cnt;
    cw   = make_codeword();
    pos  = rand_below(BLK_W);
    run_block(flip_bit(cw, pos), res, rb);
    check_eq(res, RES_FIXED, "single error outcome");
    wb_read(ADR_LOC, d);
    check_eq(d, {2'b00, 3'(pos / ROW_W), 3'(pos % ROW_W)}, "single error location");
    check_eq(rb, cw, "corrected block");
    report_test("single error", err0);

    // 4: two errors, same row then different rows and columns
    err0 = err_cnt;
    cw   = make_codeword();
    r1   = rand_below(BLK_ROWS);
    c1   = rand_below(ROW_W);
    c2   = (c1 + 1 + rand_below(ROW_W - 1)) % ROW_W;
    blk  = flip_bit(flip_bit(cw, ROW_W * r1 + c1), ROW_W * r1 + c2);
    run_block(blk, res, rb);
    check_eq(res, RES_FAIL, "same row double outcome");
    check_eq(rb, blk, "same row double unchanged");
    r2   = (r1 + 1 + rand_below(BLK_ROWS - 1)) % BLK_ROWS;
    blk  = flip_bit(flip_bit(cw, ROW_W * r1 + c1), ROW_W * r2 + c2);
    run_block(blk, res, rb);
    check_eq(res, RES_FAIL, "cross double outcome");
    check_eq(rb, blk, "cross double unchanged");
    report_test("double error", err0);

    // 5: accesses while busy
    err0 = err_cnt;
    cw   = make_codeword();
    blk  = flip_bit(cw, rand_below(BLK_W));
    idx  = 0;
    while (idx < BLK_ROWS - 1 && blk[ROW_W*idx +: ROW_W] == '0) begin
      idx++;  // a nonzero row makes the zero read visible
    end
    write_block(blk);
    wb_write(ADR_CTRL, 8'h01);
    wb_write('0, ~blk[ROW_W-1:0]);  // discarded
    wb_write(ADR_CTRL, 8'h01);       // ignored, a re-decode would end clean
    wb_read(WB_AW'(idx), d);
    check_eq(d, 8'h00, "row read during busy");
    wait_idle(d);
    check_eq(d[1:0], RES_FIXED, "outcome after busy accesses");
    read_block(rb);
    check_eq(rb, cw, "block after busy accesses");
    report_test("busy behavior", err0);

    // 6: random blocks with 0 to 3 errors
    err0 = err_cnt;
    for (int b = 0; b < 200; b++) begin
      blk = make_codeword();
      idx = rand_below(4);
      for (int e = 0; e < idx; e++) begin
        blk = flip_bit(blk, rand_below(BLK_W));  // may hit the same bit twice
      end
      run_block(blk, res, rb);
    end
    report_test("random blocks", err0);

    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // ----------------------------------------------------------
  // watchdog
  // ----------------------------------------------------------
  initial begin
    #(WD_NS);
    $display("the watchdog expired, the tests did not end within %0d ns", WD_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: list.f
rtl/btc_pkg.sv
rtl/btc_dec_mem.sv
rtl/btc_row_check.sv
rtl/btc_col_check.sv
rtl/btc_err_locate.sv
rtl/btc_dec_ctrl.sv
rtl/btc_spc_dec.sv
verif/btc_tb_clk.sv
verif/btc_spc_dec_tb.sv

// File: run.sh
#!/bin/sh
# build and run the decoder testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module btc_spc_dec_tb -o sim_btc
./obj_dir/sim_btc | tee sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failures"
